/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_core_top -Mdir obj_dir -f list.f
	./obj_dir/Vtb_core_top > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Test failures found" sim.log; then \
		echo "simulation reported failures"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* common/core_pkg.sv */
`default_nettype none

package core_pkg;

    // one machine word carries data, addresses and instruction encodings alike
    typedef logic [31:0] word_t;

    // index into the 32-entry integer register file
    typedef logic [4:0] reg_addr_t;

    // selects which value the write back stage returns to the register file
    typedef logic [2:0] result_src_t;

    // operation performed by the execute stage ALU
    typedef logic [1:0] alu_op_t;

    // decode never produces the reserved result source code 3'b011
    localparam result_src_t RES_ALU = 3'b000;
    localparam result_src_t RES_MEM = 3'b001;
    localparam result_src_t RES_PC4 = 3'b010;
    localparam result_src_t RES_IMM = 3'b100;
    localparam result_src_t RES_IN  = 3'b111;

    // ALU operations
    localparam alu_op_t ALU_ADD = 2'b00;
    localparam alu_op_t ALU_SUB = 2'b01;
    // the compare gives 1 in bit 0 when both operands are equal
    localparam alu_op_t ALU_EQ  = 2'b10;

endpackage

`default_nettype wire

/* common/core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// program counter value held while rst_n is low
`define CORE_RESET_PC 32'h0000_0000

// number of 32-bit words in the internal data memory, which must be a power of two
`define CORE_DMEM_WORDS 64

// addi x0, x0, 0 is the instruction that fills a cancelled or reset slot
`define CORE_NOP 32'h0000_0013

`endif

/* common/pipe_if.sv */
`timescale 1ns/1ns
`default_nettype none

// contents of the decode/execute pipeline register
interface decode_exec_io;
    import core_pkg::*;

    logic        reg_write;
    result_src_t result_src;
    logic        mem_write;
    alu_op_t     alu_op;
    // high when the second ALU operand is the immediate
    logic        alu_src;
    logic        branch;
    logic        jump;
    word_t       rs1_data;
    word_t       rs2_data;
    word_t       imm_ext;
    word_t       pc;
    word_t       pc_plus4;
    reg_addr_t   rd;

    modport in (output reg_write, result_src, mem_write, alu_op, alu_src, branch, jump,
                output rs1_data, rs2_data, imm_ext, pc, pc_plus4, rd);
    modport out (input reg_write, result_src, mem_write, alu_op, alu_src, branch, jump,
                 input rs1_data, rs2_data, imm_ext, pc, pc_plus4, rd);
endinterface

// contents of the execute/memory pipeline register
interface exec_mem_io;
    import core_pkg::*;

    logic        reg_write;
    result_src_t result_src;
    logic        mem_write;
    word_t       alu_result;
    // store data is taken from rs2
    word_t       write_data;
    word_t       pc_plus4;
    word_t       imm_ext;
    reg_addr_t   rd;

    modport in (output reg_write, result_src, mem_write, alu_result, write_data,
                output pc_plus4, imm_ext, rd);
    modport out (input reg_write, result_src, mem_write, alu_result, write_data,
                 input pc_plus4, imm_ext, rd);
endinterface

// control half of the memory/write-back pipeline register
interface control_mem_io;
    import core_pkg::*;

    logic        reg_write;
    result_src_t result_src;

    modport in (output reg_write, result_src);
    modport out (input reg_write, result_src);
endinterface

// data half of the memory/write-back pipeline register
interface data_mem_io;
    import core_pkg::*;

    word_t     alu_result;
    word_t     read_data;
    word_t     pc_plus4;
    word_t     imm_ext;
    reg_addr_t rd;

    modport in (output alu_result, read_data, pc_plus4, imm_ext, rd);
    modport out (input alu_result, read_data, pc_plus4, imm_ext, rd);
endinterface

`default_nettype wire

/* list.f */
+incdir+common
common/core_pkg.sv
common/pipe_if.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/exec_stage.sv
verilog/mem_stage.sv
verilog/write_back.sv
verilog/core_top.sv
test/tb_core_top.sv

/* test/tb_core_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "core_settings.svh"

module tb_core_top;
    import core_pkg::*;

    // instruction kinds that the reference model knows how to run
    localparam int K_ADD  = 0;
    localparam int K_SUB  = 1;
    localparam int K_ADDI = 2;
    localparam int K_LUI  = 3;
    localparam int K_LW   = 4;
    localparam int K_SW   = 5;
    localparam int K_BEQ  = 6;
    localparam int K_JAL  = 7;
    localparam int K_IN   = 8;
    localparam int NUM_TESTS = 6;

    logic      clk;
    logic      rst_n;
    word_t     instr;
    word_t     in_data;
    word_t     instr_addr;
    logic      reg_write_w;
    reg_addr_t rd_w;
    word_t     result_w;

    // program image together with the fields of each instruction for the reference model
    word_t     prog [$];
    int        op_q [$];
    reg_addr_t rd_q [$];
    reg_addr_t rs1_q [$];
    reg_addr_t rs2_q [$];
    word_t     imm_q [$];

    // expected write backs in program order, tagged with the test they belong to
    reg_addr_t exp_rd [$];
    word_t     exp_val [$];
    int        exp_tag [$];
    bit        exp_in [$];

    string       test_name [NUM_TESTS];
    // byte address where the code of each test starts
    int          sec_start [NUM_TESTS];
    int          test_chk [NUM_TESTS];
    int          test_err [NUM_TESTS];
    word_t       in_vals [4];
    int          in_idx;
    int          pass_cnt;
    int          fail_cnt;
    int          halt_pc;
    int          timeout_ns;
    bit          prog_ready;
    int unsigned fetch_idx;

    core_top core_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_addr  (instr_addr),
        .instr       (instr),
        .in_data     (in_data),
        .reg_write_w (reg_write_w),
        .rd_w        (rd_w),
        .result_w    (result_w)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // encodes one instruction and keeps its fields for the reference model
    task automatic emit(int op, reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2, word_t imm);
        word_t w;
        case (op)
            K_ADD:   w = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_SUB:   w = {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_ADDI:  w = {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
            K_LUI:   w = {imm[31:12], rd, 7'b0110111};
            K_LW:    w = {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
            K_SW:    w = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
            K_BEQ:   w = {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
            K_JAL:   w = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
            default: w = {20'b0, rd, 7'b0001011};
        endcase
        prog.push_back(w);
        op_q.push_back(op);
        rd_q.push_back(rd);
        rs1_q.push_back(rs1);
        rs2_q.push_back(rs2);
        imm_q.push_back(imm);
    endtask

    task automatic add_nops(int n);
        repeat (n) emit(K_ADDI, 0, 0, 0, '0);
    endtask

    function automatic word_t rand_imm12();
        logic [11:0] r;
        r = 12'($urandom);
        return {{20{r[11]}}, r};
    endfunction

    // every consumer sits at least three instructions after its producer
    task automatic build_program();
        word_t a;
        word_t base;
        foreach (in_vals[k]) in_vals[k] = $urandom;
        sec_start[0] = 0;
        emit(K_ADDI, 1, 0, 0, rand_imm12());
        sec_start[1] = prog.size() * 4;
        emit(K_ADDI, 2, 0, 0, rand_imm12());
        emit(K_LUI, 3, 0, 0, {20'($urandom), 12'b0});
        add_nops(1);
        emit(K_ADD, 4, 1, 2, '0);
        emit(K_SUB, 5, 3, 1, '0);
        emit(K_ADDI, 6, 3, 0, rand_imm12());
        add_nops(1);
        emit(K_SUB, 7, 4, 5, '0);
        // the offsets above the memory size fold back onto words near the base
        sec_start[2] = prog.size() * 4;
        base = word_t'(($urandom % 32) * 4);
        emit(K_ADDI, 10, 0, 0, base);
        add_nops(2);
        emit(K_SW, 0, 10, 4, 32'd0);
        emit(K_SW, 0, 10, 7, 32'd8);
        emit(K_SW, 0, 10, 6, word_t'(`CORE_DMEM_WORDS * 4 + 4));
        emit(K_SW, 0, 10, 5, 32'd12);
        emit(K_LW, 13, 10, 0, 32'd0);
        emit(K_LW, 14, 10, 0, word_t'(`CORE_DMEM_WORDS * 4 + 12));
        emit(K_LW, 15, 10, 0, 32'd4);
        emit(K_LW, 16, 10, 0, 32'd8);
        sec_start[3] = prog.size() * 4;
        emit(K_IN, 17, 0, 0, '0);
        emit(K_IN, 18, 0, 0, '0);
        add_nops(2);
        emit(K_ADD, 19, 17, 18, '0);
        // x20 and x21 match, x22 differs by one
        sec_start[4] = prog.size() * 4;
        a = $urandom % 2000;
        emit(K_ADDI, 20, 0, 0, a);
        emit(K_ADDI, 21, 0, 0, a);
        emit(K_ADDI, 22, 0, 0, a + 32'd1);
        add_nops(2);
        emit(K_BEQ, 0, 20, 22, 32'd8);
        emit(K_ADDI, 23, 0, 0, rand_imm12());
        emit(K_BEQ, 0, 20, 21, 32'd16);
        // these two sit in the shadow of the taken beq and must never write
        emit(K_ADDI, 24, 0, 0, 32'd1);
        emit(K_ADDI, 25, 0, 0, 32'd2);
        // the target lies one word past the shadow so only a real redirect skips this
        emit(K_ADDI, 11, 0, 0, 32'd5);
        emit(K_ADDI, 26, 0, 0, rand_imm12());
        emit(K_JAL, 27, 0, 0, 32'd16);
        emit(K_ADDI, 28, 0, 0, 32'd3);
        emit(K_ADDI, 29, 0, 0, 32'd4);
        emit(K_ADDI, 12, 0, 0, 32'd6);
        add_nops(2);
        emit(K_ADD, 30, 27, 0, '0);
        sec_start[5] = prog.size() * 4;
        emit(K_ADDI, 0, 0, 0, rand_imm12() | 32'd1);
        emit(K_ADD, 0, 1, 2, '0);
        add_nops(2);
        emit(K_ADD, 31, 0, 0, '0);
        emit(K_ADDI, 9, 0, 0, rand_imm12());
        // the core spins on a jump to itself once the program is done
        halt_pc = prog.size() * 4;
        emit(K_JAL, 0, 0, 0, '0);
    endtask

    function automatic int section_of(int pc);
        int t;
        int s;
        t = 0;
        for (s = 0; s < NUM_TESTS; s++) begin
            if (pc >= sec_start[s]) t = s;
        end
        return t;
    endfunction

    // runs the program one instruction at a time and records every register write
    task automatic run_reference();
        word_t regs [32];
        word_t dmem [`CORE_DMEM_WORDS];
        word_t val;
        word_t addr;
        int    pc;
        int    pc_next;
        int    i;
        int    in_k;
        int    steps;
        bit    wr;
        foreach (regs[r]) regs[r] = '0;
        pc = 0;
        in_k = 0;
        steps = 0;
        while (pc != halt_pc && steps < 1000) begin
            i = pc / 4;
            wr = 1'b1;
            val = '0;
            pc_next = pc + 4;
            addr = regs[rs1_q[i]] + imm_q[i];
            case (op_q[i])
                K_ADD:  val = regs[rs1_q[i]] + regs[rs2_q[i]];
                K_SUB:  val = regs[rs1_q[i]] - regs[rs2_q[i]];
                K_ADDI: val = addr;
                K_LUI:  val = imm_q[i];
                K_LW:   val = dmem[(addr >> 2) % `CORE_DMEM_WORDS];
                K_SW: begin
                    wr = 1'b0;
                    dmem[(addr >> 2) % `CORE_DMEM_WORDS] = regs[rs2_q[i]];
                end
                K_BEQ: begin
                    wr = 1'b0;
                    if (regs[rs1_q[i]] == regs[rs2_q[i]]) pc_next = pc + int'(imm_q[i]);
                end
                K_JAL: begin
                    val = word_t'(pc + 4);
                    pc_next = pc + int'(imm_q[i]);
                end
                default: val = in_vals[in_k];
            endcase
            if (wr && rd_q[i] != 5'd0) begin
                regs[rd_q[i]] = val;
                exp_rd.push_back(rd_q[i]);
                exp_val.push_back(val);
                exp_tag.push_back(section_of(pc));
                exp_in.push_back(op_q[i] == K_IN);
                if (op_q[i] == K_IN) in_k++;
            end
            pc = pc_next;
            steps++;
        end
    endtask

    task automatic report_test(int t);
        if (test_err[t] == 0) begin
            $display("test %s passed, %0d checks", test_name[t], test_chk[t]);
        end else begin
            $display("test %s failed, %0d of %0d checks wrong", test_name[t], test_err[t],
                     test_chk[t]);
        end
    endtask

    // compares one observed write back with the oldest expected one
    task automatic check_write();
        int t;
        if (exp_rd.size() == 0) begin
            $display("unexpected register write x%0d = %h after the last expected write",
                     rd_w, result_w);
            fail_cnt++;
        end else begin
            t = exp_tag[0];
            test_chk[t]++;
            assert (rd_w == exp_rd[0] && result_w == exp_val[0]) begin
                pass_cnt++;
            end else begin
                $display("FAILED %s: expected x%0d = %h, actual x%0d = %h", test_name[t],
                         exp_rd[0], exp_val[0], rd_w, result_w);
                fail_cnt++;
                test_err[t]++;
            end
            // the environment moves in_data on once an in instruction has retired
            if (exp_in[0]) in_idx++;
            void'(exp_rd.pop_front());
            void'(exp_val.pop_front());
            void'(exp_tag.pop_front());
            void'(exp_in.pop_front());
            if (exp_tag.size() == 0 || exp_tag[0] != t) report_test(t);
        end
    endtask

    // write back outputs come from registers, so they are stable at the edge
    always @(posedge clk) begin
        if (rst_n) begin
            assert (!(reg_write_w && rd_w == 5'd0)) else begin
                $display("a write to x0 reached write back with value %h", result_w);
                fail_cnt++;
                test_err[5]++;
            end
            if (reg_write_w && rd_w != 5'd0) check_write();
        end
    end

    // the instruction ROM returns the word addressed at an edge one clock later
    always @(posedge clk) begin
        fetch_idx = rst_n ? instr_addr >> 2 : 0;
        #1;
        instr <= (fetch_idx < prog.size()) ? prog[fetch_idx] : `CORE_NOP;
    end

    always @(posedge clk) begin
        #1;
        in_data <= in_vals[in_idx];
    end

    initial begin
        wait (prog_ready);
        #(timeout_ns);
        $display("watchdog expired after %0d ns with %0d expected writes still missing",
                 timeout_ns, exp_rd.size());
        $display("Test failures found");
        $finish;
    end

    task automatic final_report();
        $display("checks passed: %0d, checks failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    initial begin
        rst_n = 1'b0;
        instr = `CORE_NOP;
        in_data = '0;
        in_idx = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        prog_ready = 1'b0;
        test_name = '{"reset", "arithmetic", "memory", "in", "control", "x0"};
        void'($urandom(44482));
        build_program();
        run_reference();
        instr = prog[0];
        in_data = in_vals[0];
        // four clocks per instruction and a margin for reset and the drain
        timeout_ns = (prog.size() * 4 + 40) * 20;
        prog_ready = 1'b1;
        repeat (3) begin
            @(posedge clk);
            test_chk[0]++;
            assert (reg_write_w == 1'b0) pass_cnt++;
            else begin
                $display("reg_write_w was high while rst_n was low");
                fail_cnt++;
                test_err[0]++;
            end
        end
        #1;
        rst_n = 1'b1;
        while (exp_rd.size() != 0) @(negedge clk);
        // writes from cancelled instructions would show up within a few more cycles
        repeat (10) @(negedge clk);
        final_report();
    end
endmodule

`default_nettype wire

/* verilog/core_top.sv */
`timescale 1ns/1ns
`default_nettype none

module core_top (
    input  wire logic                clk,
    input  wire logic                rst_n,
    output core_pkg::word_t          instr_addr,
    input  wire core_pkg::word_t     instr,
    input  wire core_pkg::word_t     in_data,
    output logic                     reg_write_w,
    output core_pkg::reg_addr_t      rd_w,
    output core_pkg::word_t          result_w
);
    import core_pkg::*;

    word_t next_pc;
    word_t pc_plus4_f;
    word_t instr_d;
    word_t pc_d;
    word_t pc_plus4_d;
    logic  pc_src_e;
    word_t pc_target_e;

    decode_exec_io de_if ();
    exec_mem_io    em_if ();
    control_mem_io cm_if ();
    data_mem_io    dm_if ();

    // the external memory sees the same address that fetch loads at the next edge
    assign instr_addr = next_pc;

    fetch_stage fetch_stage_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .next_pc    (next_pc),
        .flush      (pc_src_e),
        .instr      (instr),
        .pc_plus4_f (pc_plus4_f),
        .instr_d    (instr_d),
        .pc_d       (pc_d),
        .pc_plus4_d (pc_plus4_d)
    );

    decode_stage decode_stage_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_d     (instr_d),
        .pc_d        (pc_d),
        .pc_plus4_d  (pc_plus4_d),
        .flush       (pc_src_e),
        .reg_write_w (reg_write_w),
        .rd_w        (rd_w),
        .result_w    (result_w),
        .de_if       (de_if)
    );

    exec_stage exec_stage_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .de_if       (de_if),
        .em_if       (em_if),
        .pc_src_e    (pc_src_e),
        .pc_target_e (pc_target_e)
    );

    mem_stage mem_stage_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .em_if (em_if),
        .cm_if (cm_if),
        .dm_if (dm_if)
    );

    write_back write_back_inst (
        .cm_if       (cm_if),
        .dm_if       (dm_if),
        .pc_plus4_f  (pc_plus4_f),
        .pc_src_e    (pc_src_e),
        .pc_target_e (pc_target_e),
        .in_data     (in_data),
        .next_pc     (next_pc),
        .reg_write_w (reg_write_w),
        .rd_w        (rd_w),
        .result_w    (result_w)
    );
endmodule

`default_nettype wire

/* verilog/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire core_pkg::word_t    instr_d,
    input  wire core_pkg::word_t    pc_d,
    input  wire core_pkg::word_t    pc_plus4_d,
    input  wire logic               flush,
    input  wire logic               reg_write_w,
    input  wire core_pkg::reg_addr_t rd_w,
    input  wire core_pkg::word_t    result_w,
    decode_exec_io.in               de_if
);
    import core_pkg::*;

    // major opcodes of the supported subset where custom-0 carries the in instruction
    localparam logic [6:0] OP_REG     = 7'b0110011;
    localparam logic [6:0] OP_IMM     = 7'b0010011;
    localparam logic [6:0] OP_LUI     = 7'b0110111;
    localparam logic [6:0] OP_LOAD    = 7'b0000011;
    localparam logic [6:0] OP_STORE   = 7'b0100011;
    localparam logic [6:0] OP_BRANCH  = 7'b1100011;
    localparam logic [6:0] OP_JAL     = 7'b1101111;
    localparam logic [6:0] OP_CUSTOM0 = 7'b0001011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    word_t      imm_u;

    logic        reg_write_dec;
    result_src_t result_src_dec;
    logic        mem_write_dec;
    alu_op_t     alu_op_dec;
    logic        alu_src_dec;
    logic        branch_dec;
    logic        jump_dec;
    word_t       imm_dec;
    word_t       rs1_data;
    word_t       rs2_data;

    // x0 has no storage so only x1 to x31 exist
    word_t regs [1:31];

    assign opcode = instr_d[6:0];
    assign funct3 = instr_d[14:12];
    assign funct7 = instr_d[31:25];
    assign rs1    = instr_d[19:15];
    assign rs2    = instr_d[24:20];
    assign rd     = instr_d[11:7];

    // every immediate is sign extended from instruction bit 31
    assign imm_i = {{20{instr_d[31]}}, instr_d[31:20]};
    assign imm_s = {{20{instr_d[31]}}, instr_d[31:25], instr_d[11:7]};
    assign imm_b = {{19{instr_d[31]}}, instr_d[31], instr_d[7], instr_d[30:25],
                    instr_d[11:8], 1'b0};
    assign imm_j = {{11{instr_d[31]}}, instr_d[31], instr_d[19:12], instr_d[20],
                    instr_d[30:21], 1'b0};
    assign imm_u = {instr_d[31:12], 12'b0};

    // anything outside the subset decodes to a bubble that writes nothing
    always_comb begin
        reg_write_dec  = 1'b0;
        result_src_dec = RES_ALU;
        mem_write_dec  = 1'b0;
        alu_op_dec     = ALU_ADD;
        alu_src_dec    = 1'b0;
        branch_dec     = 1'b0;
        jump_dec       = 1'b0;
        imm_dec        = imm_i;
        case (opcode)
            OP_REG: begin
                // add and sub differ only in funct7 bit 5
                if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
                    reg_write_dec = 1'b1;
                end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
                    reg_write_dec = 1'b1;
                    alu_op_dec    = ALU_SUB;
                end
            end
            OP_IMM: begin
                if (funct3 == 3'b000) begin
                    reg_write_dec = 1'b1;
                    alu_src_dec   = 1'b1;
                end
            end
            OP_LUI: begin
                // the upper immediate bypasses the ALU and comes back from write back
                reg_write_dec  = 1'b1;
                result_src_dec = RES_IMM;
                imm_dec        = imm_u;
            end
            OP_LOAD: begin
                if (funct3 == 3'b010) begin
                    reg_write_dec  = 1'b1;
                    result_src_dec = RES_MEM;
                    alu_src_dec    = 1'b1;
                end
            end
            OP_STORE: begin
                if (funct3 == 3'b010) begin
                    mem_write_dec = 1'b1;
                    alu_src_dec   = 1'b1;
                    imm_dec       = imm_s;
                end
            end
            OP_BRANCH: begin
                if (funct3 == 3'b000) begin
                    branch_dec = 1'b1;
                    alu_op_dec = ALU_EQ;
                    imm_dec    = imm_b;
                end
            end
            OP_JAL: begin
                reg_write_dec  = 1'b1;
                result_src_dec = RES_PC4;
                jump_dec       = 1'b1;
                imm_dec        = imm_j;
            end
            OP_CUSTOM0: begin
                reg_write_dec  = 1'b1;
                result_src_dec = RES_IN;
            end
            default: begin
            end
        endcase
    end

    // the register file is written at the end of the write back cycle
    always_ff @(posedge clk) begin
        if (reg_write_w && rd_w != 5'd0) begin
            regs[rd_w] <= result_w;
        end
    end

    // a write landing this cycle is visible to the read at once
    assign rs1_data = (rs1 == 5'd0) ? '0 :
                      (reg_write_w && rd_w == rs1) ? result_w : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 :
                      (reg_write_w && rd_w == rs2) ? result_w : regs[rs2];

    // flush turns the slot into a bubble, and a write to x0 is dropped here already
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            de_if.reg_write  <= 1'b0;
            de_if.result_src <= RES_ALU;
            de_if.mem_write  <= 1'b0;
            de_if.alu_op     <= ALU_ADD;
            de_if.alu_src    <= 1'b0;
            de_if.branch     <= 1'b0;
            de_if.jump       <= 1'b0;
        end else if (flush) begin
            de_if.reg_write  <= 1'b0;
            de_if.result_src <= RES_ALU;
            de_if.mem_write  <= 1'b0;
            de_if.alu_op     <= ALU_ADD;
            de_if.alu_src    <= 1'b0;
            de_if.branch     <= 1'b0;
            de_if.jump       <= 1'b0;
        end else begin
            de_if.reg_write  <= reg_write_dec && (rd != 5'd0);
            de_if.result_src <= result_src_dec;
            de_if.mem_write  <= mem_write_dec;
            de_if.alu_op     <= alu_op_dec;
            de_if.alu_src    <= alu_src_dec;
            de_if.branch     <= branch_dec;
            de_if.jump       <= jump_dec;
        end
    end

    always_ff @(posedge clk) begin
        de_if.rs1_data <= rs1_data;
        de_if.rs2_data <= rs2_data;
        de_if.imm_ext  <= imm_dec;
        de_if.pc       <= pc_d;
        de_if.pc_plus4 <= pc_plus4_d;
        de_if.rd       <= rd;
    end
endmodule

`default_nettype wire

/* verilog/exec_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_stage (
    input  wire logic       clk,
    input  wire logic       rst_n,
    decode_exec_io.out      de_if,
    exec_mem_io.in          em_if,
    output logic            pc_src_e,
    output core_pkg::word_t pc_target_e
);
    import core_pkg::*;

    word_t src_b;
    word_t alu_result;

    assign src_b = de_if.alu_src ? de_if.imm_ext : de_if.rs2_data;

    always_comb begin
        case (de_if.alu_op)
            ALU_SUB: alu_result = de_if.rs1_data - src_b;
            // beq only looks at bit 0 of the compare result
            ALU_EQ:  alu_result = {31'b0, de_if.rs1_data == src_b};
            default: alu_result = de_if.rs1_data + src_b;
        endcase
    end

    // both beq and jal are pc relative, so one adder serves as the target
    assign pc_target_e = de_if.pc + de_if.imm_ext;
    assign pc_src_e    = de_if.jump || (de_if.branch && alu_result[0]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            em_if.reg_write  <= 1'b0;
            em_if.result_src <= RES_ALU;
            em_if.mem_write  <= 1'b0;
        end else begin
            em_if.reg_write  <= de_if.reg_write;
            em_if.result_src <= de_if.result_src;
            em_if.mem_write  <= de_if.mem_write;
        end
    end

    always_ff @(posedge clk) begin
        em_if.alu_result <= alu_result;
        em_if.write_data <= de_if.rs2_data;
        em_if.pc_plus4   <= de_if.pc_plus4;
        em_if.imm_ext    <= de_if.imm_ext;
        em_if.rd         <= de_if.rd;
    end
endmodule

`default_nettype wire

/* verilog/fetch_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "core_settings.svh"

module fetch_stage (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire core_pkg::word_t next_pc,
    input  wire logic            flush,
    input  wire core_pkg::word_t instr,
    output core_pkg::word_t      pc_plus4_f,
    output core_pkg::word_t      instr_d,
    output core_pkg::word_t      pc_d,
    output core_pkg::word_t      pc_plus4_d
);
    import core_pkg::*;

    // address of the word that the instruction memory returns on instr this cycle
    word_t pc_f;

    assign pc_plus4_f = pc_f + 32'd4;

    // next_pc also addresses the external memory, so pc_f and instr stay paired
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_f <= `CORE_RESET_PC;
        end else begin
            pc_f <= next_pc;
        end
    end

    // a taken branch or jump in execute cancels the instruction fetched this cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_d <= `CORE_NOP;
        end else if (flush) begin
            instr_d <= `CORE_NOP;
        end else begin
            instr_d <= instr;
        end
    end

    // pc and pc+4 of the fetched word follow it into decode
    always_ff @(posedge clk) begin
        pc_d       <= pc_f;
        pc_plus4_d <= pc_plus4_f;
    end
endmodule

`default_nettype wire

/* verilog/mem_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "core_settings.svh"

module mem_stage (
    input  wire logic clk,
    input  wire logic rst_n,
    exec_mem_io.out   em_if,
    control_mem_io.in cm_if,
    data_mem_io.in    dm_if
);
    import core_pkg::*;

    localparam int unsigned DMEM_IDX_W = $clog2(`CORE_DMEM_WORDS);

    logic [DMEM_IDX_W-1:0] dmem_idx;

    word_t dmem [`CORE_DMEM_WORDS];

    // the byte address drops its low two bits and wraps around the memory depth
    assign dmem_idx = em_if.alu_result[DMEM_IDX_W+1:2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cm_if.reg_write  <= 1'b0;
            cm_if.result_src <= RES_ALU;
        end else begin
            cm_if.reg_write  <= em_if.reg_write;
            cm_if.result_src <= em_if.result_src;
        end
    end

    // the read is registered with the rest of the memory/write-back fields
    always_ff @(posedge clk) begin
        if (em_if.mem_write) begin
            dmem[dmem_idx] <= em_if.write_data;
        end
        dm_if.read_data  <= dmem[dmem_idx];
        dm_if.alu_result <= em_if.alu_result;
        dm_if.pc_plus4   <= em_if.pc_plus4;
        dm_if.imm_ext    <= em_if.imm_ext;
        dm_if.rd         <= em_if.rd;
    end
endmodule

`default_nettype wire

/* verilog/write_back.sv */
`timescale 1ns/1ns
`default_nettype none

module write_back (
    control_mem_io.out               cm_if,
    data_mem_io.out                  dm_if,
    input  wire core_pkg::word_t     pc_plus4_f,
    input  wire logic                pc_src_e,
    input  wire core_pkg::word_t     pc_target_e,
    input  wire core_pkg::word_t     in_data,
    output core_pkg::word_t          next_pc,
    output logic                     reg_write_w,
    output core_pkg::reg_addr_t      rd_w,
    output core_pkg::word_t          result_w
);
    import core_pkg::*;

    assign reg_write_w = cm_if.reg_write;
    assign rd_w        = dm_if.rd;

    // in_data is sampled here in write back and the environment holds it steady
    always_comb begin
        case (cm_if.result_src)
            RES_ALU: result_w = dm_if.alu_result;
            RES_MEM: result_w = dm_if.read_data;
            RES_PC4: result_w = dm_if.pc_plus4;
            RES_IMM: result_w = dm_if.imm_ext;
            RES_IN:  result_w = in_data;
            default: result_w = '0;
        endcase
    end

    // next_pc goes straight to the instruction memory as well as to fetch
    assign next_pc = pc_src_e ? pc_target_e : pc_plus4_f;
endmodule

`default_nettype wire
